/* list.f */
src/dm9000a_pkg.sv
src/rx_word_fifo.sv
src/dm9000a_bus_engine.sv
src/dm9000a_command_seq.sv
src/dm9000a_rx_top.sv
tb/dm9000a_chip_model.sv
tb/dm9000a_rx_sva.sv
tb/tb_dm9000a_rx.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module tb_dm9000a_rx -f list.f -o tb_sim

./obj_dir/tb_sim +verilator+error+limit+100 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
   exit 1
fi
grep -q "Simulation passed" sim.log

/* tb/tb_dm9000a_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dm9000a_rx import dm9000a_pkg::*;;

   localparam logic [47:0] MAC        = 48'h00_1B_2C_3D_4E_5F;
   localparam logic [63:0] MCAST      = 64'h0180_C200_0000_1100;
   localparam bit          PROM       = 1'b0;
   localparam bit          BCAST      = 1'b1;
   localparam spin_count_t RESET_SPIN = 20'd12;
   localparam spin_count_t PHY_SPIN   = 20'd24;
   localparam int          INIT_CYCLES = 2 * int'(PHY_SPIN) + int'(RESET_SPIN) + 1000;
   localparam int          NUM_PKTS   = 12;

   logic      clk_enet = 1'b0;
   logic      reset;
   logic      halt;
   logic      rx_fifo_rd_req;
   wire       enet_int;
   wire       enet_rst_n;
   wire       enet_cs_n;
   wire       enet_cmd;
   wire       enet_wr_n;
   wire       enet_rd_n;
   wire [15:0] enet_data;
   bus_word_t rx_fifo_data;
   logic      rx_fifo_empty;
   logic      link_status;

   // Packet table, lengths include the CRC.
   int         pkt_len [NUM_PKTS] = '{64, 65, 70, 61, 60, 64, 63, 80, 81, 66, 67, 90};
   logic [7:0] pkt_status [NUM_PKTS] = '{8'h00, 8'h40, 8'h00, 8'h00, 8'h00, 8'h02,
                                         8'h40, 8'h00, 8'h00, 8'h40, 8'h00, 8'h00};

   int        seed = 32'h4628_13e0;
   bus_word_t expected [$];
   int        load_ptr = 0;
   int        checks = 0;
   int        errors = 0;
   int        test_errors = 0;
   logic      slow_read = 1'b0;
   logic      halt_en = 1'b0;

   always #20 clk_enet = ~clk_enet;

   dm9000a_rx_top #(
      .MAC_ADDRESS       (MAC),
      .MULTICAST_ADDRESS (MCAST),
      .PROMISCUOUS_EN    (PROM),
      .BROADCAST_EN      (BCAST),
      .RESET_SPIN        (RESET_SPIN),
      .PHY_SPIN          (PHY_SPIN),
      .FIFO_DEPTH        (16)
   ) dut (
      .clk_enet       (clk_enet),
      .reset          (reset),
      .enet_int       (enet_int),
      .halt           (halt),
      .rx_fifo_rd_req (rx_fifo_rd_req),
      .enet_rst_n     (enet_rst_n),
      .enet_cs_n      (enet_cs_n),
      .enet_cmd       (enet_cmd),
      .enet_wr_n      (enet_wr_n),
      .enet_rd_n      (enet_rd_n),
      .enet_data      (enet_data),
      .rx_fifo_data   (rx_fifo_data),
      .rx_fifo_empty  (rx_fifo_empty),
      .link_status    (link_status)
   );

   dm9000a_chip_model chip (
      .clk_enet  (clk_enet),
      .enet_cmd  (enet_cmd),
      .enet_wr_n (enet_wr_n),
      .enet_rd_n (enet_rd_n),
      .enet_data (enet_data),
      .enet_int  (enet_int)
   );

   //////////////////////////////////////////////////////////////////////////
   // Expected words and packet loading.
   //////////////////////////////////////////////////////////////////////////

   // Word at position pos of a good packet, 0 being the length word.
   function automatic bus_word_t reference_word(input int len, input int pos,
                                                input bus_word_t raw);
      int payload_bytes;
      int payload_words;
      payload_bytes = len - 4;
      payload_words = (payload_bytes + 1) / 2;
      if (pos == 0) begin
         return bus_word_t'(payload_bytes);
      end
      if (pos == payload_words && (payload_bytes % 2) == 1) begin
         return {8'h00, raw[7:0]};
      end
      return raw;
   endfunction

   task automatic send_packet(input int idx);
      int        words;
      int        payload_words;
      logic      good;
      bus_word_t raw;
      words         = (pkt_len[idx] + 1) / 2;
      payload_words = (pkt_len[idx] - 4 + 1) / 2;
      good          = (pkt_status[idx] & 8'hBF) == 8'h00;
      chip.store_word(load_ptr, {pkt_status[idx], 8'h01});
      chip.store_word(load_ptr + 1, bus_word_t'(pkt_len[idx]));
      if (good) begin
         expected.push_back(reference_word(pkt_len[idx], 0, 16'h0000));
      end
      for (int k = 0; k < words; k++) begin
         raw = bus_word_t'($random(seed));
         chip.store_word(load_ptr + 2 + k, raw);
         if (good && k < payload_words) begin
            expected.push_back(reference_word(pkt_len[idx], k + 1, raw));
         end
      end
      load_ptr = load_ptr + words + 2;
      chip.announce_packet(load_ptr);
      repeat (3) @(negedge clk_enet);
   endtask

   // All words popped and every packet read out of the chip.
   task automatic wait_drained();
      while (expected.size() != 0 || chip.read_ptr != 10'(load_ptr) || !rx_fifo_empty) begin
         @(negedge clk_enet);
      end
      repeat (4) @(negedge clk_enet);
   endtask

   task automatic check_reg(input string name, input reg_index_t idx, input logic [7:0] exp);
      checks++;
      if (chip.regs[idx] !== exp) begin
         errors++;
         $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, chip.regs[idx], exp);
      end
   endtask

   task automatic check_pin(input string name, input logic value, input logic exp);
      checks++;
      if (value !== exp) begin
         errors++;
         $display("MISMATCH at %0t: %s is %b, expected %b", $time, name, value, exp);
      end
   endtask

   task automatic wait_link(input logic value);
      int cycles;
      cycles = 0;
      while (link_status !== value && cycles < 400) begin
         @(negedge clk_enet);
         cycles++;
      end
      checks++;
      if (link_status !== value) begin
         errors++;
         $display("link_status did not reach %b within %0d cycles", value, cycles);
      end
   endtask

   task automatic end_test(input string name);
      if (errors == test_errors) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: FAILED with %0d errors", name, errors - test_errors);
      end
      test_errors = errors;
   endtask

   //////////////////////////////////////////////////////////////////////////
   // FIFO reader, halt driver and comparison.
   //////////////////////////////////////////////////////////////////////////

   initial begin
      halt           = 1'b0;
      rx_fifo_rd_req = 1'b0;
   end

   always @(negedge clk_enet) begin
      int        r;
      bus_word_t exp;
      r              = $random(seed);
      rx_fifo_rd_req = 1'b0;
      halt           = halt_en && r[3:2] == 2'b00;
      if (!reset && !rx_fifo_empty && (!slow_read || r[1:0] == 2'b00)) begin
         rx_fifo_rd_req = 1'b1;
         if (expected.size() == 0) begin
            errors++;
            $display("MISMATCH at %0t: unexpected FIFO word %h", $time, rx_fifo_data);
         end else begin
            exp = expected.pop_front();
            checks++;
            if (rx_fifo_data !== exp) begin
               errors++;
               $display("MISMATCH at %0t: FIFO word %h, expected %h", $time, rx_fifo_data, exp);
            end
         end
      end
   end

   //////////////////////////////////////////////////////////////////////////
   // Test sequence.
   //////////////////////////////////////////////////////////////////////////

   initial begin
      reset = 1'b1;
      repeat (4) @(negedge clk_enet);
      check_pin("enet_rst_n", enet_rst_n, 1'b0);
      check_pin("enet_wr_n", enet_wr_n, 1'b1);
      check_pin("enet_rd_n", enet_rd_n, 1'b1);
      check_pin("rx_fifo_empty", rx_fifo_empty, 1'b1);
      check_pin("link_status", link_status, 1'b0);
      reset = 1'b0;
      @(negedge clk_enet);
      check_pin("enet_rst_n", enet_rst_n, 1'b1);
      check_pin("enet_cs_n", enet_cs_n, 1'b0);

      // Initialization ends with the interrupt mask write.
      while (chip.regs[REG_IMR] == 8'h00) begin
         @(negedge clk_enet);
      end
      for (int i = 0; i < 6; i++) begin
         check_reg("PAR", REG_PAR + reg_index_t'(i), MAC[8 * i +: 8]);
      end
      for (int i = 0; i < 8; i++) begin
         check_reg("MAR", REG_MAR + reg_index_t'(i),
                   MCAST[8 * i +: 8] | ((i == 7 && BCAST) ? 8'h80 : 8'h00));
      end
      check_reg("RXCR", REG_RXCR, 8'h01 | (PROM ? 8'h02 : 8'h00));
      check_reg("IMR", REG_IMR, 8'hA1);
      end_test("init");

      chip.set_link(1'b1);
      wait_link(1'b1);
      chip.set_link(1'b0);
      wait_link(1'b0);
      end_test("link");

      for (int i = 0; i < 4; i++) begin
         send_packet(i);
      end
      wait_drained();
      end_test("good packets");

      for (int i = 4; i < 7; i++) begin
         send_packet(i);
      end
      wait_drained();
      end_test("bad packet");

      slow_read = 1'b1;
      halt_en   = 1'b1;
      for (int i = 7; i < NUM_PKTS; i++) begin
         send_packet(i);
      end
      wait_drained();
      halt_en = 1'b0;
      end_test("halt and full");

      errors = errors + dut.u_bus_engine.sva.fail_count;
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   // Watchdog sized from the packet lengths.
   initial begin
      int budget;
      budget = INIT_CYCLES + 2 * 40;
      for (int i = 0; i < NUM_PKTS; i++) begin
         budget = budget + pkt_len[i] + 40;
      end
      #(budget * 40);
      $display("Timeout: run did not finish within %0d cycles", budget);
      $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

/* tb/dm9000a_rx_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module dm9000a_rx_sva import dm9000a_pkg::*; (
   input wire            clk_enet,
   input wire            reset,
   input wire            enet_cmd,
   input wire            enet_rd_n,
   input wire            enet_wr_n,
   input wire bus_word_t bus_in,
   input wire            fifo_wr_req,
   input wire            fifo_full
);

   int   fail_count = 0;
   logic status_next;
   logic frame_bad;

   // The first read after an MRCMD index carries the frame status.
   always_ff @(posedge clk_enet) begin
      if (reset) begin
         status_next <= 1'b0;
         frame_bad   <= 1'b0;
      end else if (!enet_wr_n && enet_cmd == CMD_INDEX) begin
         status_next <= bus_in[7:0] == REG_MRCMD;
      end else if (!enet_rd_n && status_next) begin
         status_next <= 1'b0;
         frame_bad   <= (bus_in[15:8] & RX_BAD_FLAGS) != 8'h00;
      end
   end

   a_strobes: assert property (@(posedge clk_enet) disable iff (reset)
      enet_rd_n || enet_wr_n)
      else begin
         fail_count++;
         $error("read and write strobes active together");
      end

   a_no_write_full: assert property (@(posedge clk_enet) disable iff (reset)
      fifo_wr_req |-> !fifo_full)
      else begin
         fail_count++;
         $error("FIFO written while full");
      end

   a_no_write_bad: assert property (@(posedge clk_enet) disable iff (reset)
      fifo_wr_req |-> !frame_bad)
      else begin
         fail_count++;
         $error("FIFO written during a bad packet");
      end

endmodule

bind dm9000a_bus_engine dm9000a_rx_sva sva (
   .clk_enet    (clk_enet),
   .reset       (reset),
   .enet_cmd    (enet_cmd),
   .enet_rd_n   (enet_rd_n),
   .enet_wr_n   (enet_wr_n),
   .bus_in      (bus_in),
   .fifo_wr_req (fifo_wr_req),
   .fifo_full   (fifo_full)
);

`default_nettype wire

/* tb/dm9000a_chip_model.sv */
`timescale 1ns/1ps
`default_nettype none

module dm9000a_chip_model import dm9000a_pkg::*; (
   input  wire            clk_enet,
   input  wire            enet_cmd,
   input  wire            enet_wr_n,
   input  wire            enet_rd_n,
   inout  wire bus_word_t enet_data,
   output logic           enet_int
);

   logic [7:0] regs [256];
   bus_word_t  pkt_mem [1024];
   logic [9:0] read_ptr = '0;
   logic [9:0] load_ptr = '0;
   reg_index_t index = '0;
   logic       link = 1'b0;
   isr_flags_t isr = '0;
   bus_word_t  read_word;

   initial begin
      for (int i = 0; i < 256; i++) begin
         regs[i] <= 8'h00;
      end
      // Empty memory reads back a ready byte of 0.
      for (int i = 0; i < 1024; i++) begin
         pkt_mem[i] = 16'h0000;
      end
   end

   always_comb begin
      case (index)
         REG_NSR:    read_word = {8'h00, 1'b0, link, 6'b000000};
         REG_ISR:    read_word = {8'h00, isr};
         // Only announced frames show a ready byte.
         REG_MRCMDX: read_word = (read_ptr != load_ptr) ? {8'h00, pkt_mem[read_ptr][7:0]}
                                                        : 16'h0000;
         REG_MRCMD:  read_word = pkt_mem[read_ptr];
         default:    read_word = {8'h00, regs[index]};
      endcase
   end

   assign enet_data = !enet_rd_n ? read_word : 'z;
   assign enet_int  = (isr & regs[REG_IMR] & ISR_ALL) != 8'h00;

   always @(posedge clk_enet) begin
      if (!enet_wr_n) begin
         if (enet_cmd == CMD_INDEX) begin
            index <= enet_data[7:0];
         end else if (index == REG_ISR) begin
            // Status flags clear when written back as ones.
            isr <= isr & ~enet_data[7:0];
         end else if (index != REG_NSR) begin
            regs[index] <= enet_data[7:0];
         end
      end
      if (!enet_rd_n && index == REG_MRCMD) begin
         read_ptr <= read_ptr + 10'd1;
      end
   end

   task automatic store_word(input int addr, input bus_word_t word);
      pkt_mem[10'(addr)] = word;
   endtask

   task automatic announce_packet(input int end_ptr);
      load_ptr              <= 10'(end_ptr);
      isr[ISR_POS_PR]       <= 1'b1;
   endtask

   task automatic set_link(input logic up);
      link                  <= up;
      isr[ISR_POS_LNKCHG]   <= 1'b1;
   endtask

endmodule

`default_nettype wire

/* src/dm9000a_rx_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dm9000a_rx_top import dm9000a_pkg::*; #(
   parameter logic [47:0] MAC_ADDRESS       = 48'h010203040506,
   parameter logic [63:0] MULTICAST_ADDRESS = 64'h0,
   parameter bit          PROMISCUOUS_EN    = 1'b1,
   parameter bit          BROADCAST_EN      = 1'b1,
   parameter spin_count_t RESET_SPIN        = 20'd20,
   parameter spin_count_t PHY_SPIN          = 20'd40,
   parameter int          FIFO_DEPTH        = 16
) (
   input  wire            clk_enet,
   input  wire            reset,
   input  wire            enet_int,
   input  wire            halt,
   input  wire            rx_fifo_rd_req,
   output logic           enet_rst_n,
   output logic           enet_cs_n,
   output logic           enet_cmd,
   output logic           enet_wr_n,
   output logic           enet_rd_n,
   inout  wire bus_word_t enet_data,
   output bus_word_t      rx_fifo_data,
   output logic           rx_fifo_empty,
   output logic           link_status
);

   logic       issue_ready;
   logic       issue_read;
   reg_index_t issue_register;
   bus_word_t  issue_data;
   logic       busy;
   bus_word_t  read_data;
   bus_word_t  bus_out;
   logic       fifo_full;
   logic       fifo_wr_req;
   bus_word_t  fifo_wr_data;

   // The chip is always selected and follows the system reset.
   assign enet_rst_n = ~reset;
   assign enet_cs_n  = 1'b0;

   // Drive the bus only during a write strobe.
   assign enet_data = !enet_wr_n ? bus_out : 'z;

   dm9000a_command_seq #(
      .MAC_ADDRESS       (MAC_ADDRESS),
      .MULTICAST_ADDRESS (MULTICAST_ADDRESS),
      .PROMISCUOUS_EN    (PROMISCUOUS_EN),
      .BROADCAST_EN      (BROADCAST_EN),
      .RESET_SPIN        (RESET_SPIN),
      .PHY_SPIN          (PHY_SPIN)
   ) u_command_seq (
      .clk_enet       (clk_enet),
      .reset          (reset),
      .enet_int       (enet_int),
      .busy           (busy),
      .read_data      (read_data),
      .issue_ready    (issue_ready),
      .issue_read     (issue_read),
      .issue_register (issue_register),
      .issue_data     (issue_data),
      .link_status    (link_status)
   );

   dm9000a_bus_engine u_bus_engine (
      .clk_enet       (clk_enet),
      .reset          (reset),
      .issue_ready    (issue_ready),
      .issue_read     (issue_read),
      .issue_register (issue_register),
      .issue_data     (issue_data),
      .busy           (busy),
      .read_data      (read_data),
      .bus_in         (enet_data),
      .bus_out        (bus_out),
      .enet_cmd       (enet_cmd),
      .enet_wr_n      (enet_wr_n),
      .enet_rd_n      (enet_rd_n),
      .fifo_full      (fifo_full),
      .halt           (halt),
      .fifo_wr_req    (fifo_wr_req),
      .fifo_wr_data   (fifo_wr_data)
   );

   rx_word_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_rx_fifo (
      .clk_enet (clk_enet),
      .reset    (reset),
      .wr_req   (fifo_wr_req),
      .wr_data  (fifo_wr_data),
      .full     (fifo_full),
      .rd_req   (rx_fifo_rd_req),
      .rd_data  (rx_fifo_data),
      .empty    (rx_fifo_empty)
   );

endmodule

`default_nettype wire

/* src/dm9000a_command_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module dm9000a_command_seq import dm9000a_pkg::*; #(
   parameter logic [47:0] MAC_ADDRESS       = 48'h010203040506,
   parameter logic [63:0] MULTICAST_ADDRESS = 64'h0,
   parameter bit          PROMISCUOUS_EN    = 1'b1,
   parameter bit          BROADCAST_EN      = 1'b1,
   parameter spin_count_t RESET_SPIN        = 20'd20,
   parameter spin_count_t PHY_SPIN          = 20'd40
) (
   input  wire            clk_enet,
   input  wire            reset,
   input  wire            enet_int,
   input  wire            busy,
   input  wire bus_word_t read_data,
   output logic           issue_ready,
   output logic           issue_read,
   output reg_index_t     issue_register,
   output bus_word_t      issue_data,
   output logic           link_status
);

   // Auto-wrap plus the link change and packet received interrupts.
   localparam isr_flags_t INT_MASK = IMR_PAR | IMR_LNKCHGI | IMR_PRI;

   cmd_state_t  state;
   cmd_state_t  post_spin_state;
   spin_count_t spin_count;
   logic [2:0]  byte_pos;
   isr_flags_t  irq_flags;
   logic [7:0]  mcast_byte;

   // Top hash bit is the broadcast entry.
   assign mcast_byte = MULTICAST_ADDRESS[{byte_pos, 3'b000} +: 8] |
                       {BROADCAST_EN && byte_pos == 3'd7, 7'b0};

   always_ff @(posedge clk_enet) begin
      if (reset) begin
         // Let the chip finish its power-on reset first.
         state           <= CMD_SPIN;
         post_spin_state <= CMD_RESET;
         spin_count      <= PHY_SPIN;
         byte_pos        <= 3'd0;
         irq_flags       <= '0;
         issue_ready     <= 1'b0;
         link_status     <= 1'b0;
      end else if (issue_ready) begin
         // The engine takes the command in this cycle.
         issue_ready <= 1'b0;
      end else if (!busy) begin
         issue_ready <= 1'b1;
         issue_read  <= 1'b0;
         case (state)
            CMD_IDLE: begin
               issue_ready <= 1'b0;
               if (enet_int) begin
                  state <= CMD_IRQ;
               end
            end
            CMD_SPIN: begin
               issue_ready <= 1'b0;
               spin_count  <= spin_count - spin_count_t'(1);
               if (spin_count == '0) begin
                  state <= post_spin_state;
               end
            end

            ////////////////////////////////////////////////////////////////////
            // Interrupt service.
            ////////////////////////////////////////////////////////////////////

            CMD_IRQ: begin
               issue_register <= REG_IMR;
               issue_data     <= {8'h00, IMR_PAR};
               state          <= CMD_IRQ_STATUS;
            end
            CMD_IRQ_STATUS: begin
               issue_read     <= 1'b1;
               issue_register <= REG_ISR;
               state          <= CMD_IRQ_CLEAR;
            end
            // Write back only the flags seen, later events stay pending.
            CMD_IRQ_CLEAR: begin
               irq_flags      <= read_data[7:0];
               issue_register <= REG_ISR;
               issue_data     <= {8'h00, read_data[7:0]};
               state          <= CMD_DISPATCH;
            end
            CMD_DISPATCH: begin
               issue_ready <= 1'b0;
               if (irq_flags[ISR_POS_PR]) begin
                  state <= CMD_RX_PACKET_0;
               end else if (irq_flags[ISR_POS_LNKCHG]) begin
                  state <= CMD_LINK_CHANGE;
               end else begin
                  state <= CMD_IRQ_FINISH;
               end
            end
            CMD_IRQ_FINISH: begin
               issue_register <= REG_IMR;
               issue_data     <= {8'h00, INT_MASK};
               state          <= CMD_IDLE;
            end
            // First pass reads the NSR, second pass takes the link bit.
            CMD_LINK_CHANGE: begin
               if (irq_flags[ISR_POS_LNKCHG]) begin
                  issue_read                <= 1'b1;
                  issue_register            <= REG_NSR;
                  irq_flags[ISR_POS_LNKCHG] <= 1'b0;
               end else begin
                  issue_ready <= 1'b0;
                  link_status <= (read_data[7:0] & NSR_LINK) != 8'h00;
                  state       <= CMD_DISPATCH;
               end
            end
            CMD_RX_PACKET_0: begin
               issue_read            <= 1'b1;
               issue_register        <= REG_MRCMDX;
               irq_flags[ISR_POS_PR] <= 1'b0;
               state                 <= CMD_RX_PACKET_1;
            end
            // Ready byte of 1 means another frame is waiting.
            CMD_RX_PACKET_1: begin
               if (read_data[7:0] == 8'h01) begin
                  issue_read     <= 1'b1;
                  issue_register <= REG_MRCMD;
                  state          <= CMD_RX_PACKET_0;
               end else begin
                  issue_ready <= 1'b0;
                  state       <= CMD_DISPATCH;
               end
            end

            ////////////////////////////////////////////////////////////////////
            // Initialization.
            ////////////////////////////////////////////////////////////////////

            CMD_RESET: begin
               issue_register  <= REG_NCR;
               issue_data      <= {8'h00, NCR_RST};
               spin_count      <= RESET_SPIN;
               post_spin_state <= CMD_PHY;
               state           <= CMD_SPIN;
            end
            CMD_PHY: begin
               issue_register  <= REG_GPR;
               issue_data      <= 16'h0000;
               spin_count      <= PHY_SPIN;
               post_spin_state <= CMD_NSR;
               state           <= CMD_SPIN;
            end
            CMD_NSR: begin
               issue_register <= REG_NSR;
               issue_data     <= {8'h00, NSR_WAKE | NSR_TX2_END | NSR_TX1_END};
               state          <= CMD_ISR;
            end
            CMD_ISR: begin
               issue_register <= REG_ISR;
               issue_data     <= {8'h00, ISR_ALL};
               byte_pos       <= 3'd0;
               state          <= CMD_MAC;
            end
            CMD_MAC: begin
               issue_register <= REG_PAR + {5'b00000, byte_pos};
               issue_data     <= {8'h00, MAC_ADDRESS[{byte_pos, 3'b000} +: 8]};
               byte_pos       <= (byte_pos == 3'd5) ? 3'd0 : byte_pos + 3'd1;
               if (byte_pos == 3'd5) begin
                  state <= CMD_MULTICAST;
               end
            end
            CMD_MULTICAST: begin
               issue_register <= REG_MAR + {5'b00000, byte_pos};
               issue_data     <= {8'h00, mcast_byte};
               byte_pos       <= byte_pos + 3'd1;
               if (byte_pos == 3'd7) begin
                  state <= CMD_RXCR;
               end
            end
            CMD_RXCR: begin
               issue_register <= REG_RXCR;
               issue_data     <= {8'h00, RXCR_RXEN | (PROMISCUOUS_EN ? RXCR_PRMSC : 8'h00)};
               state          <= CMD_IMR;
            end
            CMD_IMR: begin
               issue_register <= REG_IMR;
               issue_data     <= {8'h00, INT_MASK};
               state          <= CMD_IDLE;
            end
            default: begin
               issue_ready <= 1'b0;
               state       <= CMD_IDLE;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* src/dm9000a_bus_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module dm9000a_bus_engine import dm9000a_pkg::*; (
   input  wire             clk_enet,
   input  wire             reset,
   input  wire             issue_ready,
   input  wire             issue_read,
   input  wire reg_index_t issue_register,
   input  wire bus_word_t  issue_data,
   output logic            busy,
   output bus_word_t       read_data,
   input  wire bus_word_t  bus_in,
   output bus_word_t       bus_out,
   output logic            enet_cmd,
   output logic            enet_wr_n,
   output logic            enet_rd_n,
   input  wire             fifo_full,
   input  wire             halt,
   output logic            fifo_wr_req,
   output bus_word_t       fifo_wr_data
);

   bus_state_t state;
   bus_word_t  rx_length;
   logic       rx_odd;
   logic       rx_bad;
   logic       rx_stall;

   // Bad frames are drained at full speed, good ones wait for room.
   assign rx_stall = (fifo_full || halt) && !rx_bad;

   // A read is still in progress while its data is being captured.
   assign busy = (state != BUS_IDLE) || !enet_rd_n;

   ////////////////////////////////////////////////////////////////////////////
   // Bus cycle sequencing.
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_enet) begin
      if (reset) begin
         state     <= BUS_IDLE;
         rx_bad    <= 1'b0;
         enet_cmd  <= CMD_DATA;
         enet_wr_n <= 1'b1;
         enet_rd_n <= 1'b1;
      end else begin
         // Strobes are single-cycle pulses unless a state asks otherwise.
         enet_wr_n <= 1'b1;
         enet_rd_n <= 1'b1;
         case (state)
            BUS_IDLE: begin
               if (issue_ready) begin
                  state <= BUS_SETUP;
               end
            end
            // Write the register index.
            BUS_SETUP: begin
               enet_cmd  <= CMD_INDEX;
               enet_wr_n <= 1'b0;
               state     <= (issue_register == REG_MRCMD) ? BUS_RX_SETUP_SPIN
                                                          : BUS_SETUP_SPIN;
            end
            BUS_SETUP_SPIN: begin
               state <= issue_read ? BUS_READ : BUS_WRITE;
            end
            BUS_READ: begin
               enet_cmd  <= CMD_DATA;
               enet_rd_n <= 1'b0;
               state     <= (issue_register == REG_MRCMDX) ? BUS_PF_SPIN_0 : BUS_IDLE;
            end
            BUS_WRITE: begin
               enet_cmd  <= CMD_DATA;
               enet_wr_n <= 1'b0;
               state     <= BUS_IDLE;
            end
            // The prefetch needs a dummy read and 80 ns before the real one.
            BUS_PF_SPIN_0: state <= BUS_PF_SPIN_1;
            BUS_PF_SPIN_1: state <= BUS_PF_READ;
            BUS_PF_READ: begin
               enet_rd_n <= 1'b0;
               state     <= BUS_IDLE;
            end
            // Packet reception, status word first.
            BUS_RX_SETUP_SPIN: state <= BUS_RX_STATUS_0;
            BUS_RX_STATUS_0: begin
               enet_cmd  <= CMD_DATA;
               enet_rd_n <= 1'b0;
               state     <= BUS_RX_STATUS_1;
            end
            BUS_RX_STATUS_1: begin
               rx_bad <= (bus_in[15:8] & RX_BAD_FLAGS) != 8'h00;
               state  <= BUS_RX_LEN_0;
            end
            BUS_RX_LEN_0: begin
               enet_rd_n <= rx_stall;
               state     <= rx_stall ? BUS_RX_LEN_0 : BUS_RX_LEN_1;
            end
            BUS_RX_LEN_1: state <= BUS_RX_DATA_0;
            // Once the payload is done the first CRC read goes out here.
            BUS_RX_DATA_0: begin
               if (rx_length == '0) begin
                  enet_rd_n <= 1'b0;
                  state     <= BUS_CRC_0;
               end else begin
                  enet_rd_n <= rx_stall;
                  state     <= rx_stall ? BUS_RX_DATA_0 : BUS_RX_DATA_1;
               end
            end
            BUS_RX_DATA_1: state <= BUS_RX_DATA_0;
            BUS_CRC_0: state <= BUS_CRC_1;
            BUS_CRC_1: begin
               enet_rd_n <= 1'b0;
               state     <= BUS_CRC_2;
            end
            BUS_CRC_2: state <= BUS_IDLE;
            default: state <= BUS_IDLE;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Data path.
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_enet) begin
      case (state)
         BUS_IDLE: begin
            if (!enet_rd_n) begin
               read_data <= bus_in;
            end
         end
         BUS_SETUP: bus_out <= {8'h00, issue_register};
         BUS_WRITE: bus_out <= issue_data;
         BUS_RX_LEN_1: begin
            rx_length <= bus_in - CRC_BYTES;
            rx_odd    <= bus_in[0];
         end
         // Count down one word per read, an odd tail counts as a word.
         BUS_RX_DATA_0: begin
            if (!rx_stall && rx_length != '0) begin
               rx_length <= (rx_length == 16'd1) ? 16'd0 : rx_length - 16'd2;
            end
         end
         default: ;
      endcase
   end

   // FIFO writes happen in the sampling cycle, so full is always current.
   always_comb begin
      fifo_wr_req  = 1'b0;
      fifo_wr_data = bus_in - CRC_BYTES;
      case (state)
         BUS_RX_LEN_1: fifo_wr_req = !rx_bad;
         BUS_RX_DATA_1: begin
            fifo_wr_req  = !rx_bad;
            fifo_wr_data = (rx_length == '0 && rx_odd) ? {8'h00, bus_in[7:0]} : bus_in;
         end
         default: ;
      endcase
   end

endmodule

`default_nettype wire

/* src/rx_word_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module rx_word_fifo import dm9000a_pkg::*; #(
   parameter int FIFO_DEPTH = 16
) (
   input  wire            clk_enet,
   input  wire            reset,
   input  wire            wr_req,
   input  wire bus_word_t wr_data,
   output logic           full,
   input  wire            rd_req,
   output bus_word_t      rd_data,
   output logic           empty
);

   localparam int PTR_W = $clog2(FIFO_DEPTH);

   bus_word_t        mem [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;
   logic             push;
   logic             pop;

   assign push    = wr_req && !full;
   assign pop     = rd_req && !empty;
   assign full    = count == (PTR_W + 1)'(FIFO_DEPTH);
   assign empty   = count == '0;
   // Head word is visible without a read request.
   assign rd_data = mem[rd_ptr];

   always_ff @(posedge clk_enet) begin
      if (push) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   always_ff @(posedge clk_enet) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         wr_ptr <= wr_ptr + PTR_W'(push);
         rd_ptr <= rd_ptr + PTR_W'(pop);
         count  <= count + (PTR_W + 1)'(push) - (PTR_W + 1)'(pop);
      end
   end

endmodule

`default_nettype wire

/* src/dm9000a_pkg.sv */
`default_nettype none

package dm9000a_pkg;

   typedef logic [15:0] bus_word_t;
   typedef logic [7:0]  reg_index_t;
   typedef logic [7:0]  isr_flags_t;
   typedef logic [19:0] spin_count_t;

   typedef enum logic [4:0] {
      BUS_IDLE, BUS_SETUP, BUS_SETUP_SPIN, BUS_READ, BUS_WRITE,
      BUS_PF_SPIN_0, BUS_PF_SPIN_1, BUS_PF_READ,
      BUS_RX_SETUP_SPIN, BUS_RX_STATUS_0, BUS_RX_STATUS_1,
      BUS_RX_LEN_0, BUS_RX_LEN_1, BUS_RX_DATA_0, BUS_RX_DATA_1,
      BUS_CRC_0, BUS_CRC_1, BUS_CRC_2
   } bus_state_t;

   typedef enum logic [4:0] {
      CMD_IDLE, CMD_SPIN, CMD_IRQ, CMD_IRQ_STATUS, CMD_IRQ_CLEAR, CMD_DISPATCH,
      CMD_IRQ_FINISH, CMD_LINK_CHANGE, CMD_RX_PACKET_0, CMD_RX_PACKET_1,
      CMD_RESET, CMD_PHY, CMD_NSR, CMD_ISR, CMD_MAC, CMD_MULTICAST, CMD_RXCR, CMD_IMR
   } cmd_state_t;

   // Chip register indexes.
   localparam reg_index_t REG_NCR    = 8'h00;
   localparam reg_index_t REG_NSR    = 8'h01;
   localparam reg_index_t REG_RXCR   = 8'h05;
   localparam reg_index_t REG_PAR    = 8'h10;
   localparam reg_index_t REG_MAR    = 8'h16;
   localparam reg_index_t REG_GPR    = 8'h1F;
   localparam reg_index_t REG_MRCMDX = 8'hF0;
   localparam reg_index_t REG_MRCMD  = 8'hF2;
   localparam reg_index_t REG_ISR    = 8'hFE;
   localparam reg_index_t REG_IMR    = 8'hFF;

   // Register bit masks.
   localparam logic [7:0] NCR_RST     = 8'h01;
   localparam logic [7:0] NSR_LINK    = 8'h40;
   localparam logic [7:0] NSR_WAKE    = 8'h20;
   localparam logic [7:0] NSR_TX2_END = 8'h08;
   localparam logic [7:0] NSR_TX1_END = 8'h04;
   localparam logic [7:0] RXCR_RXEN   = 8'h01;
   localparam logic [7:0] RXCR_PRMSC  = 8'h02;
   localparam int         ISR_POS_PR     = 0;
   localparam int         ISR_POS_LNKCHG = 5;
   localparam isr_flags_t ISR_ALL     = 8'h3F;
   localparam isr_flags_t IMR_PAR     = 8'h80;
   localparam isr_flags_t IMR_LNKCHGI = 8'h20;
   localparam isr_flags_t IMR_PRI     = 8'h01;

   // Receive status bits of a bad frame; the multicast flag is not one of them.
   localparam logic [7:0] RX_BAD_FLAGS = 8'hBF;
   localparam bus_word_t  CRC_BYTES    = 16'd4;

   localparam logic CMD_INDEX = 1'b0;
   localparam logic CMD_DATA  = 1'b1;

endpackage

`default_nettype wire
